/* rtl/requant_pkg.sv */
// requantization shared types
package requant_pkg;

    // field widths
    localparam int ACC_W   = 22;
    localparam int MANT_W  = 9;
    localparam int PROD_W  = 2 * MANT_W;
    localparam int ACT_W   = 8;
    localparam int SHIFT_W = 5;

    // convolution accumulator sample
    typedef logic signed [ACC_W-1:0] acc_t;
    // normalized window or per-lane scale
    typedef logic signed [MANT_W-1:0] mant_t;
    // window times scale
    typedef logic signed [PROD_W-1:0] prod_t;
    // output activation
    typedef logic signed [ACT_W-1:0] act_t;
    // shift count and global exponent n
    typedef logic [SHIFT_W-1:0] shift_t;

    // window low bit choice, 2-bit code
    typedef enum logic [1:0] {
        WIN_13 = 2'd0,
        WIN_8  = 2'd1,
        WIN_5  = 2'd2,
        WIN_3  = 2'd3
    } win_lo_t;

    // saturation limits
    localparam act_t ACT_MAX = 8'sh7f;
    localparam act_t ACT_MIN = 8'sh80;

    // bit position of the window low bit
    function automatic shift_t win_lo_pos(win_lo_t w);
        case (w)
            WIN_8: begin
                return shift_t'(8);
            end
            WIN_5: begin
                return shift_t'(5);
            end
            WIN_3: begin
                return shift_t'(3);
            end
            default: begin
                return shift_t'(13);
            end
        endcase
    endfunction

endpackage

/* rtl/acc_normalize.sv */
// accumulator window normalizer
`timescale 1ns/1ps

module acc_normalize
    import requant_pkg::*;
#(
    parameter int DN = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  acc_t   [DN-1:0]      acc_data,
    input  logic                 acc_valid,
    input  shift_t               n,
    output mant_t  [DN-1:0]      norm_mant,
    output shift_t [DN-1:0]      norm_shift
);

    // per-lane sign run checks
    logic    run16 [DN];
    logic    run13 [DN];
    logic    run11 [DN];

    win_lo_t sel   [DN];
    shift_t  lo    [DN];
    mant_t   win   [DN];
    shift_t  cnt   [DN];

    always_comb begin
        for (int i = 0; i < DN; i++) begin
            // bits above each candidate window all copy the sign
            run16[i] = (acc_data[i][ACC_W-1:16] == {6{acc_data[i][ACC_W-1]}});
            run13[i] = (acc_data[i][ACC_W-1:13] == {9{acc_data[i][ACC_W-1]}});
            run11[i] = (acc_data[i][ACC_W-1:11] == {11{acc_data[i][ACC_W-1]}});

            // highest window that still holds the leading significant bit
            if (!run16[i]) begin
                sel[i] = WIN_13;
            end else if (!run13[i]) begin
                sel[i] = WIN_8;
            end else if (!run11[i]) begin
                sel[i] = WIN_5;
            end else begin
                sel[i] = WIN_3;
            end

            lo[i]  = win_lo_pos(sel[i]);
            win[i] = acc_data[i][lo[i] +: MANT_W];
            // n is kept at or above the window position by the source
            cnt[i] = n - lo[i];
        end
    end

    // stage 1 register, held between valid strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_mant  <= '0;
            norm_shift <= '0;
        end else if (acc_valid) begin
            for (int i = 0; i < DN; i++) begin
                norm_mant[i]  <= win[i];
                norm_shift[i] <= cnt[i];
            end
        end
    end

endmodule

/* rtl/scale_table.sv */
// per-lane scale register file
`timescale 1ns/1ps

module scale_table
    import requant_pkg::*;
#(
    parameter int DN     = 6,
    parameter int GROUPS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        scale_we,
    input  logic [$clog2(GROUPS)-1:0]   scale_addr,
    input  mant_t [DN-1:0]              scale_wdata,
    input  logic [$clog2(GROUPS)-1:0]   grp,
    input  logic                        acc_valid,
    output mant_t [DN-1:0]              rd_scale
);

    // one word of DN scales per group
    mant_t [DN-1:0] mem [GROUPS];

    // write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int g = 0; g < GROUPS; g++) begin
                mem[g] <= '0;
            end
        end else if (scale_we) begin
            mem[scale_addr] <= scale_wdata;
        end
    end

    // group read, lined up with the normalizer stage
    // same-edge write to the group is not seen yet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_scale <= '0;
        end else if (acc_valid) begin
            rd_scale <= mem[grp];
        end
    end

endmodule

/* rtl/requant_lanes.sv */
// requantization lane pipeline
`timescale 1ns/1ps

module requant_lanes
    import requant_pkg::*;
#(
    parameter int DN = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mant_t  [DN-1:0]      norm_mant,
    input  shift_t [DN-1:0]      norm_shift,
    input  mant_t  [DN-1:0]      rd_scale,
    input  logic                 acc_valid,
    input  logic                 relu_en,
    output act_t   [DN-1:0]      act_data,
    output logic                 act_valid
);

    // doubled product plus rounding headroom
    localparam int RW = PROD_W + 2;

    // valid per stage, bit 0 lines up with the normalizer output
    logic [3:0] vld_q;
    // relu flag, bit 1 lines up with the product register
    logic [1:0] relu_q;

    // stage 2
    prod_t  prod_q  [DN];
    shift_t shift_q [DN];

    // stage 3 combinational
    logic signed [RW-1:0] dbl [DN];
    logic signed [RW-1:0] rnd [DN];
    act_t                 res [DN];

    // stage 3 register
    act_t res_q [DN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= '0;
            relu_q <= '0;
        end else begin
            vld_q  <= {vld_q[2:0], acc_valid};
            relu_q <= {relu_q[0], relu_en};
        end
    end

    // signed product, shift count follows along
    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            for (int i = 0; i < DN; i++) begin
                prod_q[i]  <= prod_t'($signed(norm_mant[i]) * $signed(rd_scale[i]));
                shift_q[i] <= norm_shift[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DN; i++) begin
            // 2P keeps the first dropped bit for rounding
            dbl[i] = {{2{prod_q[i][PROD_W-1]}}, prod_q[i]} <<< 1;

            // floor((2P >> s) + 1) / 2, round half up
            rnd[i] = ((dbl[i] >>> shift_q[i]) + RW'(1)) >>> 1;

            // clamp after rounding so +127.5 stays at +127
            if (rnd[i] > RW'(ACT_MAX)) begin
                res[i] = ACT_MAX;
            end else if (rnd[i] < RW'(ACT_MIN)) begin
                res[i] = ACT_MIN;
            end else begin
                res[i] = act_t'(rnd[i]);
            end

            // relu on the product sign
            if (relu_q[1] && prod_q[i][PROD_W-1]) begin
                res[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vld_q[1]) begin
            for (int i = 0; i < DN; i++) begin
                res_q[i] <= res[i];
            end
        end
    end

    // output register holds between valid pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_data <= '0;
        end else if (vld_q[2]) begin
            for (int i = 0; i < DN; i++) begin
                act_data[i] <= res_q[i];
            end
        end
    end

    assign act_valid = vld_q[3];

endmodule

/* rtl/requant_top.sv */
// requantization stage top level
`timescale 1ns/1ps

module requant_top
    import requant_pkg::*;
#(
    parameter int DN     = 6,
    parameter int GROUPS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // accumulator input
    input  acc_t  [DN-1:0]              acc_data,
    input  logic                        acc_valid,
    input  logic [$clog2(GROUPS)-1:0]   grp,
    input  shift_t                      n,
    input  logic                        relu_en,

    // scale table write port
    input  logic                        scale_we,
    input  logic [$clog2(GROUPS)-1:0]   scale_addr,
    input  mant_t [DN-1:0]              scale_wdata,

    // activation output
    output act_t  [DN-1:0]              act_data,
    output logic                        act_valid
);

    mant_t  [DN-1:0] norm_mant;
    shift_t [DN-1:0] norm_shift;
    mant_t  [DN-1:0] rd_scale;

    acc_normalize #(
        .DN         (DN)
    ) u_acc_normalize (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_data   (acc_data),
        .acc_valid  (acc_valid),
        .n          (n),
        .norm_mant  (norm_mant),
        .norm_shift (norm_shift)
    );

    scale_table #(
        .DN          (DN),
        .GROUPS      (GROUPS)
    ) u_scale_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .scale_we    (scale_we),
        .scale_addr  (scale_addr),
        .scale_wdata (scale_wdata),
        .grp         (grp),
        .acc_valid   (acc_valid),
        .rd_scale    (rd_scale)
    );

    requant_lanes #(
        .DN         (DN)
    ) u_requant_lanes (
        .clk        (clk),
        .rst_n      (rst_n),
        .norm_mant  (norm_mant),
        .norm_shift (norm_shift),
        .rd_scale   (rd_scale),
        .acc_valid  (acc_valid),
        .relu_en    (relu_en),
        .act_data   (act_data),
        .act_valid  (act_valid)
    );

endmodule

/* testbench/requant_checker.sv */
// requantization result checker
`timescale 1ns/1ps

module requant_checker
    import requant_pkg::*;
#(
    parameter int DN     = 6,
    parameter int GROUPS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  acc_t  [DN-1:0]              acc_data,
    input  logic                        acc_valid,
    input  logic [$clog2(GROUPS)-1:0]   grp,
    input  shift_t                      n,
    input  logic                        relu_en,
    input  logic                        scale_we,
    input  logic [$clog2(GROUPS)-1:0]   scale_addr,
    input  mant_t [DN-1:0]              scale_wdata,
    input  act_t  [DN-1:0]              act_data,
    input  logic                        act_valid,
    output int                          error_count,
    output int                          pending
);

    mant_t [DN-1:0] tbl [GROUPS];
    act_t  [DN-1:0] exp_q [$];
    int             checked;

    initial begin
        error_count = 0;
        pending     = 0;
        checked     = 0;
    end

    // bits 21 down to low all equal the sign
    function automatic bit sign_run(acc_t a, int low);
        for (int b = low; b < ACC_W; b++) begin
            if (a[b] != a[ACC_W-1]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic act_t model_lane(acc_t a, mant_t scale, shift_t nn, logic r);
        int lo;
        int x;
        int p;
        int q;
        lo = !sign_run(a, 16) ? 13 : !sign_run(a, 13) ? 8 : !sign_run(a, 11) ? 5 : 3;
        x = (int'(a) >>> lo) & 511;
        if (x >= 256) begin
            x = x - 512;
        end
        p = x * int'(scale);
        q = (((2 * p) >>> (int'(nn) - lo)) + 1) >>> 1;
        if (q > 127) begin
            q = 127;
        end else if (q < -128) begin
            q = -128;
        end
        if (r && p < 0) begin
            q = 0;
        end
        return act_t'(q);
    endfunction

    always @(posedge clk or negedge rst_n) begin
        act_t [DN-1:0] e;
        if (!rst_n) begin
            for (int g = 0; g < GROUPS; g++) begin
                tbl[g] = '0;
            end
            exp_q.delete();
        end else begin
            if (act_valid) begin
                if (exp_q.size() == 0) begin
                    $display("act_valid went high with no result expected");
                    error_count++;
                end else begin
                    e = exp_q.pop_front();
                    checked++;
                    for (int i = 0; i < DN; i++) begin
                        if (act_data[i] !== e[i]) begin
                            $display("** Error act_data lane %0d: expected %h, actual %h",
                                     i, e[i], act_data[i]);
                            error_count++;
                        end
                    end
                end
            end
            // read sees the table before this edge's write
            if (acc_valid) begin
                for (int i = 0; i < DN; i++) begin
                    e[i] = model_lane(acc_data[i], tbl[grp][i], n, relu_en);
                end
                exp_q.push_back(e);
            end
            if (scale_we) begin
                tbl[scale_addr] = scale_wdata;
            end
        end
        pending = exp_q.size();
    end

    task automatic print_summary();
        $display("checked %0d results, %0d errors", checked, error_count);
    endtask

endmodule

/* testbench/requant_assert.sv */
// requantization timing assertions
`timescale 1ns/1ps

module requant_assert
    import requant_pkg::*;
#(
    parameter int DN = 6
) (
    input logic            clk,
    input logic            rst_n,
    input logic            acc_valid,
    input logic            act_valid,
    input act_t [DN-1:0]   act_data
);

    // no output during reset
    assert property (@(posedge clk) !rst_n |-> !act_valid)
        else $error("act_valid high during reset");

    // fixed four cycle latency
    assert property (@(posedge clk) disable iff (!rst_n) acc_valid |-> ##4 act_valid)
        else $error("act_valid missing 4 cycles after acc_valid");

    assert property (@(posedge clk) disable iff (!rst_n) act_valid |-> $past(acc_valid, 4))
        else $error("act_valid without acc_valid 4 cycles before");

    // data held between pulses
    assert property (@(posedge clk) disable iff (!rst_n) !act_valid |-> $stable(act_data))
        else $error("act_data changed while act_valid low");

endmodule

bind requant_top requant_assert #(
    .DN        (DN)
) u_requant_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_valid (acc_valid),
    .act_valid (act_valid),
    .act_data  (act_data)
);

/* testbench/tb_requant.sv */
// requantization stage testbench
`timescale 1ns/1ps

module tb_requant
    import requant_pkg::*;
();

    localparam int DN     = 6;
    localparam int GROUPS = 4;
    localparam int GW     = $clog2(GROUPS);

    logic                clk;
    logic                rst_n;
    acc_t  [DN-1:0]      acc_data;
    logic                acc_valid;
    logic  [GW-1:0]      grp;
    shift_t              n;
    logic                relu_en;
    logic                scale_we;
    logic  [GW-1:0]      scale_addr;
    mant_t [DN-1:0]      scale_wdata;
    act_t  [DN-1:0]      act_data;
    logic                act_valid;
    int                  error_count;
    int                  pending;

    requant_top #(
        .DN          (DN),
        .GROUPS      (GROUPS)
    ) u_requant_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_data    (acc_data),
        .acc_valid   (acc_valid),
        .grp         (grp),
        .n           (n),
        .relu_en     (relu_en),
        .scale_we    (scale_we),
        .scale_addr  (scale_addr),
        .scale_wdata (scale_wdata),
        .act_data    (act_data),
        .act_valid   (act_valid)
    );

    requant_checker #(
        .DN          (DN),
        .GROUPS      (GROUPS)
    ) u_requant_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_data    (acc_data),
        .acc_valid   (acc_valid),
        .grp         (grp),
        .n           (n),
        .relu_en     (relu_en),
        .scale_we    (scale_we),
        .scale_addr  (scale_addr),
        .scale_wdata (scale_wdata),
        .act_data    (act_data),
        .act_valid   (act_valid),
        .error_count (error_count),
        .pending     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // accumulator biased toward one of the four window positions
    function automatic acc_t random_acc();
        int   width;
        int   mode;
        acc_t v;
        case ($urandom_range(0, 3))
            0: width = 11;
            1: width = 13;
            2: width = 16;
            default: width = 22;
        endcase
        mode = $urandom_range(0, 5);
        if (mode == 0) begin
            v = acc_t'((1 << (width - 1)) - 1);
        end else if (mode == 1) begin
            v = acc_t'(-(1 << (width - 1)));
        end else begin
            v = acc_t'($urandom) << (ACC_W - width);
            v = v >>> (ACC_W - width);
        end
        return v;
    endfunction

    function automatic acc_t [DN-1:0] random_word();
        acc_t [DN-1:0] w;
        for (int i = 0; i < DN; i++) begin
            w[i] = random_acc();
        end
        return w;
    endfunction

    function automatic mant_t [DN-1:0] random_scales();
        mant_t [DN-1:0] s;
        for (int i = 0; i < DN; i++) begin
            s[i] = mant_t'($urandom);
        end
        return s;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        acc_valid <= 1'b0;
        scale_we  <= 1'b0;
    endtask

    task automatic write_group(input logic [GW-1:0] g, input mant_t [DN-1:0] s);
        @(posedge clk);
        acc_valid   <= 1'b0;
        scale_we    <= 1'b1;
        scale_addr  <= g;
        scale_wdata <= s;
    endtask

    task automatic send_word(input acc_t [DN-1:0] d, input logic [GW-1:0] g,
                             input shift_t nn, input logic r);
        @(posedge clk);
        acc_data  <= d;
        acc_valid <= 1'b1;
        grp       <= g;
        n         <= nn;
        relu_en   <= r;
        scale_we  <= 1'b0;
    endtask

    // table write and read of the same group on one edge
    task automatic send_and_write(input acc_t [DN-1:0] d, input logic [GW-1:0] g,
                                  input shift_t nn, input mant_t [DN-1:0] s);
        @(posedge clk);
        acc_data    <= d;
        acc_valid   <= 1'b1;
        grp         <= g;
        n           <= nn;
        relu_en     <= 1'($urandom);
        scale_we    <= 1'b1;
        scale_addr  <= g;
        scale_wdata <= s;
    endtask

    task automatic random_burst(input int count);
        for (int k = 0; k < count; k++) begin
            send_word(random_word(), GW'($urandom), shift_t'($urandom_range(13, 26)),
                      1'($urandom));
            if ($urandom_range(0, 3) == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();
    endtask

    task automatic directed_rounding();
        mant_t [DN-1:0] s;
        acc_t  [DN-1:0] d;
        s = '{mant_t'(-256), mant_t'(16), mant_t'(128), mant_t'(128),
              mant_t'(128), mant_t'(128)};
        // +0.5, -0.5, +1.5, -1.5, +127.5 and a large negative product
        d = '{acc_t'(65280), acc_t'(65280), acc_t'(-96), acc_t'(96),
              acc_t'(-32), acc_t'(32)};
        write_group(GW'(GROUPS - 1), s);
        send_word(d, GW'(GROUPS - 1), shift_t'(13), 1'b0);
        send_word(d, GW'(GROUPS - 1), shift_t'(13), 1'b1);
        idle_cycle();
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(32'he5eee81e));
        rst_n       = 1'b0;
        acc_data    = '0;
        acc_valid   = 1'b0;
        grp         = '0;
        n           = shift_t'(13);
        relu_en     = 1'b0;
        scale_we    = 1'b0;
        scale_addr  = '0;
        scale_wdata = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int g = 0; g < GROUPS; g++) begin
            write_group(GW'(g), random_scales());
        end
        idle_cycle();
        random_burst(200);
        directed_rounding();

        // rewrites between bursts, some on the read edge
        for (int b = 0; b < 6; b++) begin
            write_group(GW'($urandom), random_scales());
            send_and_write(random_word(), GW'($urandom), shift_t'($urandom_range(13, 26)),
                           random_scales());
            random_burst(40);
        end

        // drain, looking between edges
        wait_cycles = 0;
        @(negedge clk);
        while (pending != 0 && wait_cycles < 50) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results never came out of the DUT", pending);
            u_requant_checker.print_summary();
            $display("Simulation failed");
            $finish;
        end else begin
            u_requant_checker.print_summary();
            if (error_count == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // overall run limit
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycles);
        u_requant_checker.print_summary();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* requant_top.f */
rtl/requant_pkg.sv
rtl/acc_normalize.sv
rtl/scale_table.sv
rtl/requant_lanes.sv
rtl/requant_top.sv
testbench/requant_checker.sv
testbench/requant_assert.sv
testbench/tb_requant.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the requantization testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_requant \
    -f requant_top.f \
    -Mdir obj_dir

./obj_dir/Vtb_requant | tee sim.log

if grep -q "Simulation passed" sim.log; then
    echo "run passed"
    exit 0
else
    echo "run failed"
    exit 1
fi
